//--- bench/pmp_unit_checks.sv
`default_nettype none

`include "pmp_macros.svh"

module pmp_unit_checks
  import pmp_pkg::*;
(
  input  logic        clock,
  input  logic        reset,
  input  logic        wb_cyc,
  input  logic        wb_stb,
  input  logic        wb_we,
  input  logic [11:0] wb_adr,
  input  logic [31:0] wb_dat_w,
  input  logic        wb_ack,
  input  logic [31:0] wb_dat_r,
  input  logic        check_valid,
  input  logic [31:0] check_addr,
  input  access_t     check_kind,
  input  logic [1:0]  check_mode,
  input  logic        check_done,
  input  logic        check_fault,
  output logic        failed
);

  timeunit 1ns;
  timeprecision 1ps;

  localparam int CFG_WORDS = `PMP_REGIONS / 4;

  logic [7:0]  shadow_cfg [`PMP_REGIONS];
  logic [31:0] shadow_addr [`PMP_REGIONS];
  logic        bus_req;
  logic        exp_ack;
  logic        exp_read;
  logic [31:0] exp_rdata;
  logic        exp_done;
  logic        exp_fault;

  initial failed = 1'b0;

  task automatic report_mismatch(input string name, input logic [31:0] got,
                                 input logic [31:0] expected);
    $display("error %s: got 0x%h, expected 0x%h", name, got, expected);
    failed = 1'b1;
  endtask

  // ######################################################################
  // Shadow register model
  // ######################################################################

  function automatic logic [31:0] csr_read_value(input logic [11:0] adr);
    logic [31:0] value;
    value = '0; // Unmapped reads zero
    for (int j = 0; j < CFG_WORDS; j++) begin
      if (adr == 12'(`CSR_PMPCFG0 + j)) begin
        value = {shadow_cfg[4*j+3], shadow_cfg[4*j+2], shadow_cfg[4*j+1], shadow_cfg[4*j]};
      end
    end
    for (int i = 0; i < `PMP_REGIONS; i++) begin
      if (adr == 12'(`CSR_PMPADDR0 + i)) begin
        value = shadow_addr[i];
      end
    end
    return value;
  endfunction

  function automatic logic addr_write_blocked(input int i);
    if (shadow_cfg[i][7]) begin
      return 1'b1;
    end
    if (i < `PMP_REGIONS - 1) begin
      if (shadow_cfg[i+1][7] && shadow_cfg[i+1][4:3] == TOR) begin
        return 1'b1; // Base of a locked TOR region
      end
    end
    return 1'b0;
  endfunction

  function automatic int trailing_ones(input logic [31:0] value);
    int count;
    count = 0;
    while (count < 32 && value[count]) begin
      count++;
    end
    return count;
  endfunction

  // Lowest matching region decides, byte bounds in 64 bits
  function automatic logic expected_fault(input logic [31:0] addr, input access_t kind,
                                          input logic [1:0] mode);
    logic [63:0] a;
    logic [63:0] lo;
    logic [63:0] hi;
    logic [63:0] size;
    logic [31:0] prev;
    logic        perm;
    a = {32'd0, addr};
    for (int i = 0; i < `PMP_REGIONS; i++) begin
      prev = 32'd0;
      if (i > 0) begin
        prev = shadow_addr[i-1];
      end
      lo = 64'd0;
      hi = 64'd0;
      case (shadow_cfg[i][4:3])
        TOR: begin
          lo = {32'd0, prev} << 2;
          hi = {32'd0, shadow_addr[i]} << 2;
        end
        NA4: begin
          lo = {32'd0, shadow_addr[i]} << 2;
          hi = lo + 64'd4;
        end
        NAPOT: begin
          size = 64'd1 << (trailing_ones(shadow_addr[i]) + 3);
          lo = ({32'd0, shadow_addr[i]} << 2) & ~(size - 64'd1);
          hi = lo + size;
        end
        default: ;
      endcase
      if (a >= lo && a < hi) begin
        case (kind)
          FETCH:   perm = shadow_cfg[i][2];
          LOAD:    perm = shadow_cfg[i][0];
          STORE:   perm = shadow_cfg[i][1];
          default: perm = 1'b0;
        endcase
        if (shadow_cfg[i][7]) begin
          return !perm;
        end
        return !perm && mode != `MODE_M;
      end
    end
    return mode != `MODE_M;
  endfunction

  assign bus_req = wb_cyc && wb_stb && !exp_ack;

  always @(posedge clock) begin
    if (!reset) begin
      exp_ack   <= 1'b0;
      exp_read  <= 1'b0;
      exp_rdata <= '0;
      exp_done  <= 1'b0;
      exp_fault <= 1'b0;
      for (int i = 0; i < `PMP_REGIONS; i++) begin
        shadow_cfg[i]  <= '0;
        shadow_addr[i] <= '0;
      end
    end else begin
      exp_ack  <= bus_req;
      exp_read <= bus_req && !wb_we;
      if (bus_req && !wb_we) begin
        exp_rdata <= csr_read_value(wb_adr);
      end
      if (bus_req && wb_we) begin
        for (int j = 0; j < CFG_WORDS; j++) begin
          if (wb_adr == 12'(`CSR_PMPCFG0 + j)) begin
            for (int b = 0; b < 4; b++) begin
              if (!shadow_cfg[4*j+b][7]) begin
                shadow_cfg[4*j+b] <= wb_dat_w[8*b +: 8] & 8'h9F; // Reserved bits drop
              end
            end
          end
        end
        for (int i = 0; i < `PMP_REGIONS; i++) begin
          if (wb_adr == 12'(`CSR_PMPADDR0 + i) && !addr_write_blocked(i)) begin
            shadow_addr[i] <= wb_dat_w;
          end
        end
      end
      exp_done  <= check_valid;
      exp_fault <= check_valid && expected_fault(check_addr, check_kind, check_mode);
    end
  end

  // ######################################################################
  // Port checks
  // ######################################################################

  a_wb_ack : assert property (@(posedge clock) disable iff (!reset) wb_ack == exp_ack)
    else report_mismatch("wb_ack", 32'($sampled(wb_ack)), 32'($sampled(exp_ack)));

  a_wb_dat_r : assert property (@(posedge clock) disable iff (!reset)
    exp_read |-> wb_dat_r == exp_rdata)
    else report_mismatch("wb_dat_r", $sampled(wb_dat_r), $sampled(exp_rdata));

  a_check_done : assert property (@(posedge clock) disable iff (!reset)
    check_done == exp_done)
    else report_mismatch("check_done", 32'($sampled(check_done)), 32'($sampled(exp_done)));

  a_check_fault : assert property (@(posedge clock) disable iff (!reset)
    check_fault == exp_fault)
    else report_mismatch("check_fault", 32'($sampled(check_fault)),
                         32'($sampled(exp_fault)));

endmodule

`default_nettype wire

//--- bench/pmp_unit_tb.sv
`default_nettype none

`include "pmp_macros.svh"

module pmp_unit_tb
  import pmp_pkg::*;
();

  timeunit 1ns;
  timeprecision 1ps;

  localparam int CFG_WORDS = `PMP_REGIONS / 4;

  logic        clock;
  logic        reset;
  logic        wb_cyc;
  logic        wb_stb;
  logic        wb_we;
  logic [11:0] wb_adr;
  logic [31:0] wb_dat_w;
  logic        wb_ack;
  logic [31:0] wb_dat_r;
  logic        check_valid;
  logic [31:0] check_addr;
  access_t     check_kind;
  logic [1:0]  check_mode;
  logic        check_done;
  logic        check_fault;
  logic        failed;
  logic [31:0] lcg_state;

  // Region edges of the main setup, probed with small offsets
  logic [31:0] edge_list [10] = '{32'h0000_2000, 32'h0000_3000, 32'h0000_4000,
                                  32'h0000_4004, 32'h0000_8000, 32'h0000_9000,
                                  32'h0001_0000, 32'h0002_0000, 32'h0000_0000,
                                  32'hFFFF_FFF0};

  pmp_unit u_dut (
    .clock       (clock),
    .reset       (reset),
    .wb_cyc      (wb_cyc),
    .wb_stb      (wb_stb),
    .wb_we       (wb_we),
    .wb_adr      (wb_adr),
    .wb_dat_w    (wb_dat_w),
    .wb_ack      (wb_ack),
    .wb_dat_r    (wb_dat_r),
    .check_valid (check_valid),
    .check_addr  (check_addr),
    .check_kind  (check_kind),
    .check_mode  (check_mode),
    .check_done  (check_done),
    .check_fault (check_fault)
  );

  pmp_unit_checks u_checks (.*);

  always #50 clock = ~clock;

  task automatic stop_with_failure(input string reason);
    $display("%s", reason);
    $display("tests failed");
    $fatal(1, "simulation stopped");
  endtask

  always @(posedge failed) stop_with_failure("a port assertion reported a mismatch");

  function automatic logic [31:0] next_random();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  function automatic access_t pick_kind(input logic [31:0] r);
    case (r % 3)
      0:       return FETCH;
      1:       return LOAD;
      default: return STORE;
    endcase
  endfunction

  // ######################################################################
  // Bus and check port drivers
  // ######################################################################

  task automatic bus_cycle(input logic [11:0] adr, input logic we, input logic [31:0] data);
    int waited;
    @(negedge clock);
    wb_cyc   = 1'b1;
    wb_stb   = 1'b1;
    wb_we    = we;
    wb_adr   = adr;
    wb_dat_w = data;
    waited   = 0;
    @(negedge clock);
    while (!wb_ack) begin
      waited++;
      if (waited > 16) begin
        stop_with_failure("no Wishbone ack within 16 cycles");
      end
      @(negedge clock);
    end
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
    wb_we  = 1'b0;
  endtask

  task automatic write_csr(input logic [11:0] adr, input logic [31:0] data);
    bus_cycle(adr, 1'b1, data);
  endtask

  task automatic read_csr(input logic [11:0] adr);
    bus_cycle(adr, 1'b0, 32'd0);
  endtask

  task automatic read_all_csrs();
    for (int j = 0; j < CFG_WORDS; j++) begin
      read_csr(12'(`CSR_PMPCFG0 + j));
    end
    for (int i = 0; i < `PMP_REGIONS; i++) begin
      read_csr(12'(`CSR_PMPADDR0 + i));
    end
  endtask

  task automatic issue_check(input logic [31:0] addr, input access_t kind,
                             input logic [1:0] mode);
    @(negedge clock);
    check_valid = 1'b1; // Left high for back-to-back requests
    check_addr  = addr;
    check_kind  = kind;
    check_mode  = mode;
  endtask

  task automatic drain_checks();
    int waited;
    @(negedge clock);
    check_valid = 1'b0;
    waited = 0;
    while (check_done) begin
      waited++;
      if (waited > 4) begin
        stop_with_failure("check_done stayed high after the requests stopped");
      end
      @(negedge clock);
    end
  endtask

  task automatic random_checks(input int count, input logic random_mode);
    logic [31:0] r;
    logic [31:0] addr;
    logic [1:0]  mode;
    int          idx;
    for (int n = 0; n < count; n++) begin
      r = next_random();
      idx = int'(r[7:4]) % 10;
      addr = edge_list[idx] + {28'd0, r[3:0]} - 32'd8;
      if (r[31:30] == 2'b00) begin
        addr = next_random();
      end
      mode = `MODE_U;
      if (random_mode && r[20]) begin
        mode = `MODE_M;
      end
      issue_check(addr, pick_kind(r >> 8), mode);
      if (r[29:27] == 3'b000) begin
        drain_checks(); // Occasional gap between requests
      end
    end
    drain_checks();
  endtask

  // ######################################################################
  // Stimulus
  // ######################################################################

  initial begin
    clock       = 1'b0;
    reset       = 1'b0;
    wb_cyc      = 1'b0;
    wb_stb      = 1'b0;
    wb_we       = 1'b0;
    wb_adr      = '0;
    wb_dat_w    = '0;
    check_valid = 1'b0;
    check_addr  = '0;
    check_kind  = LOAD;
    check_mode  = `MODE_U;
    lcg_state   = 32'hd598e30d;
    repeat (4) @(posedge clock);
    @(negedge clock);
    reset = 1'b1;

    // Reset state
    read_all_csrs();
    issue_check(32'h0000_1000, LOAD, `MODE_U);
    issue_check(32'h0000_1000, LOAD, `MODE_M);
    drain_checks();

    // Register access with random contents, no lock bits
    for (int j = 0; j < CFG_WORDS; j++) begin
      write_csr(12'(`CSR_PMPCFG0 + j), next_random() & 32'h7F7F7F7F);
    end
    for (int i = 0; i < `PMP_REGIONS; i++) begin
      write_csr(12'(`CSR_PMPADDR0 + i), next_random());
    end
    read_all_csrs();
    random_checks(40, 1'b1);
    write_csr(12'h3C0, 32'hDEAD_BEEF); // Unmapped
    read_csr(12'h3C0);
    read_csr(12'h3A2);
    read_csr(12'h000);
    for (int j = 0; j < CFG_WORDS; j++) begin
      write_csr(12'(`CSR_PMPCFG0 + j), 32'd0);
    end

    // TOR, NA4 and NAPOT regions
    write_csr(`CSR_PMPADDR0 + 12'd0, 32'h0000_0800);
    write_csr(`CSR_PMPADDR0 + 12'd1, 32'h0000_0C00);
    write_csr(`CSR_PMPADDR0 + 12'd2, 32'h0000_1000);
    write_csr(`CSR_PMPADDR0 + 12'd3, 32'h0000_21FF);
    write_csr(`CSR_PMPADDR0 + 12'd4, 32'h0000_5FFF);
    write_csr(`CSR_PMPADDR0 + 12'd5, 32'h0000_0100); // Empty TOR range
    write_csr(`CSR_PMPADDR0 + 12'd6, 32'h0000_0000);
    write_csr(`CSR_PMPADDR0 + 12'd7, 32'h0000_0000);
    write_csr(`CSR_PMPCFG0, 32'h1C13_0D00);
    write_csr(`CSR_PMPCFG0 + 12'd1, 32'h0000_0F1F);
    read_all_csrs();
    random_checks(200, 1'b0);

    // Overlap of region 1 and region 6
    write_csr(`CSR_PMPADDR0 + 12'd6, 32'h0000_0BFF);
    write_csr(`CSR_PMPCFG0 + 12'd1, 32'h001F_0F1F);
    issue_check(32'h0000_2100, STORE, `MODE_U);
    issue_check(32'h0000_2FFC, STORE, `MODE_U);
    issue_check(32'h0000_3000, STORE, `MODE_U);
    issue_check(32'h0000_3F00, FETCH, `MODE_U);
    issue_check(32'h0000_2100, LOAD, `MODE_U);
    drain_checks();

    // Locked region 7 binds machine mode
    write_csr(`CSR_PMPADDR0 + 12'd7, 32'h0000_1400);
    write_csr(`CSR_PMPCFG0 + 12'd1, 32'h911F_0F1F);
    issue_check(32'h0000_5000, STORE, `MODE_M);
    issue_check(32'h0000_5002, LOAD, `MODE_M);
    issue_check(32'h0000_5000, FETCH, `MODE_M);
    issue_check(32'h0000_2100, STORE, `MODE_M);
    issue_check(32'h0000_2100, STORE, `MODE_U);
    issue_check(32'h0000_7000, LOAD, `MODE_M);
    issue_check(32'h0000_7000, LOAD, `MODE_U);
    drain_checks();
    write_csr(`CSR_PMPCFG0 + 12'd1, 32'h001F_0F1E);
    write_csr(`CSR_PMPADDR0 + 12'd7, 32'h0000_2000);
    read_csr(`CSR_PMPCFG0 + 12'd1);
    read_csr(`CSR_PMPADDR0 + 12'd7);
    issue_check(32'h0000_5000, STORE, `MODE_M);
    issue_check(32'h0001_0000, LOAD, `MODE_U);
    drain_checks();

    // Locked TOR region 5 freezes pmpaddr4
    write_csr(`CSR_PMPADDR0 + 12'd5, 32'h0000_9000);
    write_csr(`CSR_PMPCFG0 + 12'd1, 32'h001F_891F);
    write_csr(`CSR_PMPADDR0 + 12'd4, 32'h0000_1234);
    write_csr(`CSR_PMPADDR0 + 12'd5, 32'h0000_0000);
    write_csr(`CSR_PMPADDR0 + 12'd3, 32'h0000_23FF);
    write_csr(`CSR_PMPADDR0 + 12'd6, 32'h0000_0DFF);
    read_all_csrs();
    issue_check(32'h0002_1000, STORE, `MODE_M);
    issue_check(32'h0002_1000, LOAD, `MODE_M);
    issue_check(32'h0001_A000, STORE, `MODE_M);
    issue_check(32'h0002_1000, STORE, `MODE_U);
    issue_check(32'h0000_9800, FETCH, `MODE_U);
    drain_checks();
    random_checks(60, 1'b1);

    @(negedge clock);
    if (failed) begin
      stop_with_failure("a port assertion reported a mismatch");
    end else begin
      $display("all tests passed");
      $finish;
    end
  end

endmodule

`default_nettype wire

//--- include/pmp_macros.svh
`ifndef PMP_MACROS_SVH
`define PMP_MACROS_SVH

// ######################################################################
// Region count
// ######################################################################

`define PMP_REGIONS 8 // Multiple of 4, one pmpcfg word per 4 regions

// ######################################################################
// CSR numbers and privilege codes
// ######################################################################

`define CSR_PMPCFG0 12'h3A0 // First pmpcfg word
`define CSR_PMPADDR0 12'h3B0 // First pmpaddr register

`define MODE_M 2'b11
`define MODE_U 2'b00

`endif

//--- logic/pmp_csr_file.sv
`default_nettype none

`include "pmp_macros.svh"

module pmp_csr_file
  import pmp_pkg::*;
(
  input  logic        clock,
  input  logic        reset,
  input  logic        wb_cyc,
  input  logic        wb_stb,
  input  logic        wb_we,
  input  logic [11:0] wb_adr,
  input  logic [31:0] wb_dat_w,
  output logic        wb_ack,
  output logic [31:0] wb_dat_r,
  output pmp_cfg_t    region_cfg [`PMP_REGIONS],
  output logic [31:0] region_addr [`PMP_REGIONS]
);

  localparam int CFG_WORDS = `PMP_REGIONS / 4;

  logic         wb_req;
  logic         addr_wr_block [`PMP_REGIONS];
  pmpcfg_word_u wr_word;
  pmp_cfg_t     wr_cfg [4];
  logic [31:0]  rd_data;

  if (`PMP_REGIONS % 4 != 0) begin : g_bad_count
    $error("PMP_REGIONS must be a multiple of 4");
  end

  // New request only when no ack is outstanding
  assign wb_req = wb_cyc && wb_stb && !wb_ack;

  assign wr_word.raw = wb_dat_w;

  always_comb begin
    for (int b = 0; b < 4; b++) begin
      wr_cfg[b] = wr_word.cfg[b];
      wr_cfg[b].rsvd = 2'b00; // Reserved bits not stored
    end
  end

  // ######################################################################
  // Lock rules for pmpaddr writes
  // ######################################################################

  for (genvar i = 0; i < `PMP_REGIONS; i++) begin : g_lock
    if (i == `PMP_REGIONS - 1) begin : g_last
      assign addr_wr_block[i] = region_cfg[i].lock;
    end else begin : g_mid
      // Locked TOR region above also owns this register as its base
      assign addr_wr_block[i] = region_cfg[i].lock ||
                                (region_cfg[i+1].lock && region_cfg[i+1].amode == TOR);
    end
  end

  // ######################################################################
  // Register file and ack
  // ######################################################################

  always_ff @(posedge clock) begin
    if (!reset) begin
      wb_ack <= 1'b0;
      for (int i = 0; i < `PMP_REGIONS; i++) begin
        region_cfg[i]  <= '0;
        region_addr[i] <= '0;
      end
    end else begin
      wb_ack <= wb_req;
      if (wb_req && wb_we) begin
        for (int j = 0; j < CFG_WORDS; j++) begin
          if (wb_adr == 12'(`CSR_PMPCFG0 + j)) begin
            for (int b = 0; b < 4; b++) begin
              if (!region_cfg[4*j+b].lock) begin
                region_cfg[4*j+b] <= wr_cfg[b];
              end
            end
          end
        end
        for (int i = 0; i < `PMP_REGIONS; i++) begin
          if (wb_adr == 12'(`CSR_PMPADDR0 + i) && !addr_wr_block[i]) begin
            region_addr[i] <= wb_dat_w;
          end
        end
      end
    end
  end

  // Unmapped numbers fall through to zero
  always_comb begin
    pmpcfg_word_u rd_word;
    rd_word.raw = '0;
    rd_data = '0;
    for (int j = 0; j < CFG_WORDS; j++) begin
      if (wb_adr == 12'(`CSR_PMPCFG0 + j)) begin
        for (int b = 0; b < 4; b++) begin
          rd_word.cfg[b] = region_cfg[4*j+b];
        end
        rd_data = rd_word.raw;
      end
    end
    for (int i = 0; i < `PMP_REGIONS; i++) begin
      if (wb_adr == 12'(`CSR_PMPADDR0 + i)) begin
        rd_data = region_addr[i];
      end
    end
  end

  always_ff @(posedge clock) begin
    if (wb_req && !wb_we) begin
      wb_dat_r <= rd_data; // Valid with ack
    end
  end

  // ######################################################################
  // Bus protocol checks
  // ######################################################################

  a_ack_single : assert property (@(posedge clock) disable iff (!reset)
    wb_ack |=> !wb_ack);

  a_ack_after_stb : assert property (@(posedge clock) disable iff (!reset)
    wb_ack |-> $past(wb_cyc && wb_stb));

endmodule

`default_nettype wire

//--- logic/pmp_pkg.sv
`default_nettype none

package pmp_pkg;

  // Address matching mode of one region
  typedef enum logic [1:0] {
    OFF   = 2'd0,
    TOR   = 2'd1,
    NA4   = 2'd2,
    NAPOT = 2'd3
  } pmp_amode_t;

  // One pmpcfg byte, MSB first
  typedef struct packed {
    logic       lock;
    logic [1:0] rsvd; // Always read as zero
    pmp_amode_t amode;
    logic       x;
    logic       w;
    logic       r;
  } pmp_cfg_t;

  // A pmpcfg CSR holds four region bytes, region 4n in the low byte
  typedef union packed {
    logic [31:0]        raw;
    pmp_cfg_t [3:0]     cfg;
  } pmpcfg_word_u;

  typedef enum logic [1:0] {
    FETCH = 2'd0,
    LOAD  = 2'd1,
    STORE = 2'd2
  } access_t;

endpackage

`default_nettype wire

//--- logic/pmp_priority_select.sv
`default_nettype none

`include "pmp_macros.svh"

module pmp_priority_select (
  input  logic       clock,
  input  logic       reset,
  input  logic       check_valid,
  input  logic [1:0] check_mode,
  input  logic       hit [`PMP_REGIONS],
  input  logic       allow [`PMP_REGIONS],
  input  logic       locked [`PMP_REGIONS],
  output logic       check_done,
  output logic       check_fault
);

  logic any_hit;
  logic sel_allow;
  logic sel_locked;
  logic machine;
  logic fault_next;

  // Walk downwards so the lowest hitting region is left selected
  always_comb begin
    any_hit    = 1'b0;
    sel_allow  = 1'b0;
    sel_locked = 1'b0;
    for (int i = `PMP_REGIONS - 1; i >= 0; i--) begin
      if (hit[i]) begin
        any_hit    = 1'b1;
        sel_allow  = allow[i];
        sel_locked = locked[i];
      end
    end
  end

  assign machine = (check_mode == `MODE_M);

  always_comb begin
    if (!any_hit) begin
      fault_next = !machine; // No match: only M-mode passes
    end else if (sel_locked) begin
      fault_next = !sel_allow; // Lock binds M-mode too
    end else begin
      fault_next = !sel_allow && !machine;
    end
  end

  always_ff @(posedge clock) begin
    if (!reset) begin
      check_done  <= 1'b0;
      check_fault <= 1'b0;
    end else begin
      check_done  <= check_valid;
      check_fault <= check_valid && fault_next;
    end
  end

  a_fault_with_done : assert property (@(posedge clock) disable iff (!reset)
    check_fault |-> check_done && $past(check_valid));

endmodule

`default_nettype wire

//--- logic/pmp_region_match.sv
`default_nettype none

module pmp_region_match
  import pmp_pkg::*;
(
  input  pmp_cfg_t    cfg,
  input  logic [31:0] addr_reg,
  input  logic [31:0] prev_addr_reg,
  input  logic [31:0] check_addr,
  input  access_t     check_kind,
  output logic        hit,
  output logic        allow
);

  // Bounds are byte addresses, upper bound exclusive; 35 bits hold a full 2^34 top
  logic [34:0] req_addr;
  logic [31:0] napot_mask;
  logic [34:0] lo_bound;
  logic [34:0] hi_bound;
  logic        in_range;

  assign req_addr = {3'b000, check_addr};

  // Trailing ones plus the first zero, in word units
  assign napot_mask = addr_reg ^ (addr_reg + 32'd1);

  always_comb begin
    case (cfg.amode)
      TOR: begin
        lo_bound = {1'b0, prev_addr_reg, 2'b00};
        hi_bound = {1'b0, addr_reg, 2'b00};
      end
      NA4: begin
        lo_bound = {1'b0, addr_reg, 2'b00};
        hi_bound = {1'b0, addr_reg, 2'b00} + 35'd4;
      end
      NAPOT: begin
        lo_bound = {1'b0, addr_reg & ~napot_mask, 2'b00};
        hi_bound = {1'b0, addr_reg & ~napot_mask, 2'b00} +
                   {1'b0, napot_mask, 2'b00} + 35'd4; // Size is (mask + 1) words
      end
      default: begin
        lo_bound = '0;
        hi_bound = '0;
      end
    endcase
  end

  // An empty TOR range has lo >= hi and cannot match
  assign in_range = (req_addr >= lo_bound) && (req_addr < hi_bound);
  assign hit = (cfg.amode != OFF) && in_range;

  always_comb begin
    case (check_kind)
      FETCH:   allow = cfg.x;
      LOAD:    allow = cfg.r;
      STORE:   allow = cfg.w;
      default: allow = 1'b0;
    endcase
  end

endmodule

`default_nettype wire

//--- logic/pmp_unit.sv
`default_nettype none

`include "pmp_macros.svh"

module pmp_unit
  import pmp_pkg::*;
(
  input  logic        clock,
  input  logic        reset,
  // Wishbone configuration port
  input  logic        wb_cyc,
  input  logic        wb_stb,
  input  logic        wb_we,
  input  logic [11:0] wb_adr,
  input  logic [31:0] wb_dat_w,
  output logic        wb_ack,
  output logic [31:0] wb_dat_r,
  // Access check port
  input  logic        check_valid,
  input  logic [31:0] check_addr,
  input  access_t     check_kind,
  input  logic [1:0]  check_mode,
  output logic        check_done,
  output logic        check_fault
);

  pmp_cfg_t    region_cfg [`PMP_REGIONS];
  logic [31:0] region_addr [`PMP_REGIONS];
  logic        hit [`PMP_REGIONS];
  logic        allow [`PMP_REGIONS];
  logic        locked [`PMP_REGIONS];

  pmp_csr_file u_csr_file (
    .clock       (clock),
    .reset       (reset),
    .wb_cyc      (wb_cyc),
    .wb_stb      (wb_stb),
    .wb_we       (wb_we),
    .wb_adr      (wb_adr),
    .wb_dat_w    (wb_dat_w),
    .wb_ack      (wb_ack),
    .wb_dat_r    (wb_dat_r),
    .region_cfg  (region_cfg),
    .region_addr (region_addr)
  );

  // ######################################################################
  // Region matchers
  // ######################################################################

  for (genvar i = 0; i < `PMP_REGIONS; i++) begin : g_region
    logic [31:0] prev_addr;

    if (i == 0) begin : g_first
      assign prev_addr = '0; // TOR base of region 0
    end else begin : g_rest
      assign prev_addr = region_addr[i-1];
    end

    assign locked[i] = region_cfg[i].lock;

    pmp_region_match u_match (
      .cfg           (region_cfg[i]),
      .addr_reg      (region_addr[i]),
      .prev_addr_reg (prev_addr),
      .check_addr    (check_addr),
      .check_kind    (check_kind),
      .hit           (hit[i]),
      .allow         (allow[i])
    );
  end

  pmp_priority_select u_select (
    .clock       (clock),
    .reset       (reset),
    .check_valid (check_valid),
    .check_mode  (check_mode),
    .hit         (hit),
    .allow       (allow),
    .locked      (locked),
    .check_done  (check_done),
    .check_fault (check_fault)
  );

endmodule

`default_nettype wire

//--- pmp_unit.f
+incdir+include
logic/pmp_pkg.sv
logic/pmp_region_match.sv
logic/pmp_priority_select.sv
logic/pmp_csr_file.sv
logic/pmp_unit.sv
bench/pmp_unit_checks.sv
bench/pmp_unit_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the PMP unit testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --assert \
  -f pmp_unit.f \
  --top-module pmp_unit_tb

# The simulation status is judged from the log below
./obj_dir/Vpmp_unit_tb > sim.log 2>&1 || true
cat sim.log

if grep -q "tests failed" sim.log; then
  exit 1
fi

grep -q "all tests passed" sim.log
